/* verilog.f */
verilog/icache_pkg.sv
verilog/sdp_ram.sv
verilog/icache_way.sv
verilog/icache.sv
verilog/line_refill_axil.sv
verilog/fetch_subsystem.sv
sim/axil_mem_model.sv
sim/tb_fetch_subsystem.sv

/* Bender.yml */
package:
  name: fetch_subsystem

sources:
  - files:
      - verilog/icache_pkg.sv
      - verilog/sdp_ram.sv
      - verilog/icache_way.sv
      - verilog/icache.sv
      - verilog/line_refill_axil.sv
      - verilog/fetch_subsystem.sv
  - target: simulation
    files:
      - sim/axil_mem_model.sv
      - sim/tb_fetch_subsystem.sv

/* sim/tb_fetch_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_subsystem;

    import icache_pkg::*;

    localparam int          SETS          = 128;
    localparam logic [31:0] DATA_KEY      = 32'h3c5a_0f96;
    localparam int          SWEEP_TIMEOUT = SETS + 50;
    localparam int          FETCH_TIMEOUT = 400;
    localparam int          IDLE_CYCLES   = 20;

    logic       clk;
    logic       reset;
    addr_t      pc;
    logic       req;
    logic       stall;
    word_t      inst;
    logic       inst_valid;
    logic       arvalid;
    logic       arready;
    addr_t      araddr;
    logic [2:0] arprot;
    logic       rvalid;
    logic       rready;
    word_t      rdata;
    logic [1:0] rresp;

    // stimulus table: name, first pc, words in a row, expected ar handshakes
    string names[$];
    addr_t pcs[$];
    int    word_counts[$];
    int    read_counts[$];

    addr_t      ar_log[$];
    logic [2:0] prot_log[$];
    int         ar_count;
    int         passed;
    int         failed;
    logic       timed_out;

    fetch_subsystem #(
        .SETS(SETS)
    ) dut (
        .clk       (clk),
        .reset     (reset),
        .pc        (pc),
        .req       (req),
        .stall     (stall),
        .inst      (inst),
        .inst_valid(inst_valid),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .arprot    (arprot),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp)
    );

    axil_mem_model u_mem (
        .clk    (clk),
        .reset  (reset),
        .arvalid(arvalid),
        .arready(arready),
        .araddr (araddr),
        .rvalid (rvalid),
        .rready (rready),
        .rdata  (rdata),
        .rresp  (rresp)
    );

    always #2 clk = ~clk;

    // log every ar handshake
    always @(posedge clk) begin
        if (!reset && arvalid && arready) begin
            ar_count = ar_count + 1;
            ar_log.push_back(araddr);
            prot_log.push_back(arprot);
        end
    end

    function automatic word_t rule_word(input addr_t a);
        return {a[31:2], 2'b00} ^ DATA_KEY;
    endfunction

    task automatic add_entry(input string name, input addr_t a, input int words, input int reads);
        names.push_back(name);
        pcs.push_back(a);
        word_counts.push_back(words);
        read_counts.push_back(reads);
    endtask

    // set 5 holds tags 2, 5 and 9
    task automatic build_table();
        add_entry("cold_miss", 32'h0000_20a8, 1, 8);
        add_entry("same_line_hit", 32'h0000_20b4, 1, 0);
        add_entry("back_to_back_hits", 32'h0000_20a0, 4, 0);
        add_entry("second_way_miss", 32'h0000_50a0, 1, 8);
        add_entry("alternate_a", 32'h0000_20ac, 1, 0);
        add_entry("alternate_b", 32'h0000_50ac, 1, 0);
        add_entry("alternate_a_again", 32'h0000_20bc, 1, 0);
        add_entry("alternate_b_again", 32'h0000_50b0, 2, 0);
        add_entry("touch_a", 32'h0000_20a4, 1, 0);
        add_entry("third_tag_miss", 32'h0000_90a0, 1, 8);
        add_entry("a_survives", 32'h0000_20b8, 1, 0);
        add_entry("b_evicted", 32'h0000_50a4, 1, 8);
        add_entry("a_still_hits", 32'h0000_20a0, 1, 0);
        add_entry("c_evicted", 32'h0000_90bc, 1, 8);
        add_entry("other_set_miss", 32'h0001_f3e4, 1, 8);
        add_entry("other_set_hits", 32'h0001_f3e0, 8, 0);
        add_entry("high_address_miss", 32'h8000_0040, 1, 8);
        add_entry("high_address_hits", 32'h8000_0054, 3, 0);
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errs);
        end
    endtask

    task automatic check_after_reset();
        int   errs;
        int   cycles;
        logic swept;
        errs   = 0;
        cycles = 0;
        swept  = 1'b0;
        repeat (10) begin
            @(posedge clk);
            if (!stall) begin
                $display("after_reset: stall low while reset is high");
                errs++;
            end
        end
        #1;
        reset = 1'b0;
        // valid sweep keeps stall high
        while (!swept && cycles < SWEEP_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            swept = !stall;
        end
        #1;
        if (!swept) begin
            $display("after_reset: stall still high %0d cycles after reset", cycles);
            errs++;
            timed_out = 1'b1;
        end else begin
            repeat (IDLE_CYCLES) begin
                @(posedge clk);
                if (arvalid || rready || inst_valid) begin
                    $display("after_reset: arvalid, rready or inst_valid high with no request");
                    errs++;
                end
            end
            #1;
        end
        report_test("after_reset", errs);
    endtask

    task automatic run_entry(input int n);
        string name;
        addr_t base;
        addr_t line_base;
        addr_t exp_addr;
        word_t exp_word;
        int    words;
        int    exp_reads;
        int    start_count;
        int    issued;
        int    got;
        int    cycles;
        int    last_valid;
        int    errs;
        name        = names[n];
        base        = pcs[n];
        words       = word_counts[n];
        exp_reads   = read_counts[n];
        line_base   = {base[31:5], 5'b0};
        start_count = ar_count;
        issued      = 0;
        got         = 0;
        cycles      = 0;
        last_valid  = 0;
        errs        = 0;
        ar_log.delete();
        prot_log.delete();
        pc  = base;
        req = 1'b1;
        while (got < words && cycles < FETCH_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            if (inst_valid && got == issued) begin
                $display("%s: inst_valid with no request outstanding", name);
                errs++;
            end else if (inst_valid) begin
                exp_word = rule_word(base + addr_t'(4 * got));
                if (inst !== exp_word) begin
                    $display("error %s word %0d: expected %h actual %h",
                             name, got, exp_word, inst);
                    errs++;
                end
                // hits stream one word per cycle
                if (exp_reads == 0 && got > 0 && cycles != last_valid + 1) begin
                    $display("%s: hit word %0d came %0d cycles after the one before",
                             name, got, cycles - last_valid);
                    errs++;
                end
                last_valid = cycles;
                got++;
            end else if (issued > got && !stall) begin
                $display("%s: stall fell before word %0d was delivered", name, got);
                errs++;
            end
            if (req && !stall) begin
                issued++;
            end
            #1;
            if (issued < words) begin
                pc = base + addr_t'(4 * issued);
            end else begin
                req = 1'b0;
            end
        end
        if (got < words) begin
            $display("%s: no inst_valid for word %0d within %0d cycles", name, got, cycles);
            errs++;
            timed_out = 1'b1;
            req       = 1'b0;
        end else if (ar_count - start_count != exp_reads) begin
            $display("error %s reads: expected %0d actual %0d",
                     name, exp_reads, ar_count - start_count);
            errs++;
        end else begin
            for (int k = 0; k < ar_log.size(); k++) begin
                exp_addr = line_base + addr_t'(4 * k);
                if (ar_log[k] !== exp_addr) begin
                    $display("error %s araddr %0d: expected %h actual %h",
                             name, k, exp_addr, ar_log[k]);
                    errs++;
                end
                if (prot_log[k] !== 3'b100) begin
                    $display("error %s arprot %0d: expected %b actual %b",
                             name, k, 3'b100, prot_log[k]);
                    errs++;
                end
            end
        end
        report_test(name, errs);
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        pc        = '0;
        req       = 1'b0;
        ar_count  = 0;
        passed    = 0;
        failed    = 0;
        timed_out = 1'b0;
        build_table();
        check_after_reset();
        for (int n = 0; n < names.size(); n++) begin
            if (!timed_out) begin
                run_entry(n);
            end
        end
        $display("tests: %0d passed, %0d failed", passed, failed);
        if (failed == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/axil_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_mem_model (
    input  logic        clk,
    input  logic        reset,
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp
);

    localparam logic [31:0] DATA_KEY  = 32'h3c5a_0f96;
    localparam logic [31:0] LFSR_SEED = 32'h8571_08ae;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic [31:0] lfsr;
    logic [31:0] pend_addr;
    logic        pending;
    logic        ar_fire;
    logic        r_fire;
    logic        ar_seen;
    logic [31:0] ar_addr_s;
    int          ar_wait;
    int          ar_cnt;
    int          r_wait;
    int          r_cnt;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // two bits per delay, so 0 to 3 cycles
    task automatic draw_delay(output int d);
        d = 0;
        for (int i = 0; i < 2; i++) begin
            d = (d << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    initial begin
        lfsr      = LFSR_SEED;
        arready   = 1'b0;
        rvalid    = 1'b0;
        rdata     = '0;
        rresp     = 2'b00;
        pending   = 1'b0;
        pend_addr = '0;
        ar_cnt    = 0;
        r_cnt     = 0;
        r_wait    = 0;
        draw_delay(ar_wait);
    end

    always @(posedge clk) begin
        // handshakes as the DUT sees them at this edge
        ar_fire   = arvalid && arready;
        r_fire    = rvalid && rready;
        ar_seen   = arvalid;
        ar_addr_s = araddr;
        #1;
        if (reset) begin
            arready = 1'b0;
            rvalid  = 1'b0;
            pending = 1'b0;
            ar_cnt  = 0;
        end else begin
            if (r_fire) begin
                rvalid  = 1'b0;
                pending = 1'b0;
            end
            if (ar_fire) begin
                arready   = 1'b0;
                pending   = 1'b1;
                pend_addr = {ar_addr_s[31:2], 2'b00};
                r_cnt     = 0;
                draw_delay(r_wait);
            end else if (ar_seen && !arready && !pending) begin
                if (ar_cnt >= ar_wait) begin
                    arready = 1'b1;
                    ar_cnt  = 0;
                    draw_delay(ar_wait);
                end else begin
                    ar_cnt++;
                end
            end
            if (pending && !rvalid) begin
                if (r_cnt >= r_wait) begin
                    rvalid = 1'b1;
                    rdata  = pend_addr ^ DATA_KEY;
                end else begin
                    r_cnt++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_subsystem #(
    parameter int SETS = 128
) (
    input  logic              clk,
    input  logic              reset,
    input  icache_pkg::addr_t pc,
    input  logic              req,
    output logic              stall,
    output icache_pkg::word_t inst,
    output logic              inst_valid,
    output logic              arvalid,
    input  logic              arready,
    output icache_pkg::addr_t araddr,
    output logic [2:0]        arprot,
    input  logic              rvalid,
    output logic              rready,
    input  icache_pkg::word_t rdata,
    input  logic [1:0]        rresp
);

    import icache_pkg::*;

    logic  line_req;
    addr_t line_addr;
    logic  line_valid;
    line_t line_data;

    icache #(
        .SETS(SETS)
    ) u_icache (
        .clk       (clk),
        .reset     (reset),
        .pc        (pc),
        .req       (req),
        .stall     (stall),
        .inst      (inst),
        .inst_valid(inst_valid),
        .line_req  (line_req),
        .line_addr (line_addr),
        .line_valid(line_valid),
        .line_data (line_data)
    );

    line_refill_axil u_refill (
        .clk       (clk),
        .reset     (reset),
        .line_req  (line_req),
        .line_addr (line_addr),
        .line_valid(line_valid),
        .line_data (line_data),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .arprot    (arprot),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp)
    );

endmodule

`default_nettype wire

/* verilog/line_refill_axil.sv */
`timescale 1ns/1ps
`default_nettype none

module line_refill_axil (
    input  logic              clk,
    input  logic              reset,
    input  logic              line_req,
    input  icache_pkg::addr_t line_addr,
    output logic              line_valid,
    output icache_pkg::line_t line_data,
    output logic              arvalid,
    input  logic              arready,
    output icache_pkg::addr_t araddr,
    output logic [2:0]        arprot,
    input  logic              rvalid,
    output logic              rready,
    input  icache_pkg::word_t rdata,
    input  logic [1:0]        rresp
);

    import icache_pkg::*;

    localparam int WORD_W = $bits(word_t);
    localparam int LINE_W = $bits(line_t);

    refill_state_t            state;
    logic [WORD_SEL_BITS-1:0] beat;
    logic [31:OFFSET_BITS]    base;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RF_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                RF_IDLE: begin
                    if (line_req) begin
                        beat  <= '0;
                        state <= RF_ADDR;
                    end
                end
                RF_ADDR: begin
                    if (arready) begin
                        state <= RF_DATA;
                    end
                end
                RF_DATA: begin
                    // one read outstanding, next address after the data
                    if (rvalid) begin
                        beat <= beat + 1'b1;
                        if (beat == WORD_SEL_BITS'(WORDS_PER_LINE - 1)) begin
                            state <= RF_DONE;
                        end else begin
                            state <= RF_ADDR;
                        end
                    end
                end
                RF_DONE: begin
                    state <= RF_IDLE;
                end
                default: begin
                    state <= RF_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RF_IDLE && line_req) begin
            base <= line_addr[31:OFFSET_BITS];
        end
        // words arrive in order, so shift down from the top
        if (state == RF_DATA && rvalid) begin
            line_data <= {rdata, line_data[LINE_W-1:WORD_W]};
        end
    end

    assign araddr     = {base, beat, {WORD_SEL_LSB{1'b0}}};
    assign arvalid    = (state == RF_ADDR);
    assign rready     = (state == RF_DATA);
    assign line_valid = (state == RF_DONE);

    // unprivileged, secure, instruction
    assign arprot = 3'b100;

    assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr));

    assert property (@(posedge clk) disable iff (reset) line_req |-> state == RF_IDLE);

    assert property (@(posedge clk) disable iff (reset)
        rvalid && rready |-> !$isunknown({rresp, rdata}));

endmodule

`default_nettype wire

/* verilog/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache #(
    parameter int  SETS  = 128,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = 32 - IDX_W - icache_pkg::OFFSET_BITS
) (
    input  logic              clk,
    input  logic              reset,
    input  icache_pkg::addr_t pc,
    input  logic              req,
    output logic              stall,
    output icache_pkg::word_t inst,
    output logic              inst_valid,
    output logic              line_req,
    output icache_pkg::addr_t line_addr,
    input  logic              line_valid,
    input  icache_pkg::line_t line_data
);

    import icache_pkg::*;

    localparam int WORD_W = $bits(word_t);

    cache_state_t             state;
    logic                     req_q;
    addr_t                    addr_q;
    logic [IDX_W-1:0]         idx_q;
    logic [TAG_W-1:0]         tag_q;
    logic [WORD_SEL_BITS-1:0] sel_q;
    logic [IDX_W-1:0]         ram_idx;
    logic [IDX_W-1:0]         init_cnt;
    logic                     init_busy;
    logic [SETS-1:0]          lru;
    logic                     victim;
    logic                     hit0;
    logic                     hit1;
    logic                     hit_any;
    logic                     hit_svc;
    logic                     miss;
    logic                     fill;
    logic                     we0;
    logic                     we1;
    line_t                    rline0;
    line_t                    rline1;
    word_t                    hit_word;
    word_t                    fill_word;

    // tracks the valid sweep running inside the ways
    always_ff @(posedge clk) begin
        if (reset) begin
            init_cnt  <= '0;
            init_busy <= 1'b1;
        end else if (init_busy) begin
            init_cnt <= init_cnt + 1'b1;
            if (init_cnt == IDX_W'(SETS - 1)) begin
                init_busy <= 1'b0;
            end
        end
    end

    // accepted request
    always_ff @(posedge clk) begin
        if (!stall) begin
            addr_q <= pc;
        end
    end

    assign idx_q = addr_q[OFFSET_BITS +: IDX_W];
    assign tag_q = addr_q[31 -: TAG_W];
    assign sel_q = addr_q[WORD_SEL_LSB +: WORD_SEL_BITS];

    // hold the ram index while stalled
    assign ram_idx = stall ? idx_q : pc[OFFSET_BITS +: IDX_W];

    assign hit_any = hit0 | hit1;
    assign hit_svc = (state == CS_RUN) && req_q && hit_any;
    assign miss    = (state == CS_RUN) && req_q && !hit_any;
    assign fill    = (state == CS_MISS) && line_valid;

    assign stall = reset || init_busy || (state != CS_RUN) || miss;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= CS_RUN;
            req_q <= 1'b0;
        end else begin
            case (state)
                CS_RUN: begin
                    if (miss) begin
                        state <= CS_MISS;
                    end
                end
                CS_MISS: begin
                    if (line_valid) begin
                        state <= CS_FILL;
                    end
                end
                CS_FILL: begin
                    state <= CS_RUN;
                end
                default: begin
                    state <= CS_RUN;
                end
            endcase
            if (!stall) begin
                req_q <= req;
            end else if (state == CS_FILL) begin
                // word already forwarded at line arrival
                req_q <= 1'b0;
            end
        end
    end

    // lru bit names the victim way
    assign victim = lru[idx_q];
    assign we0    = fill && !victim;
    assign we1    = fill && victim;

    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (fill) begin
            lru[idx_q] <= ~victim;
        end else if (hit_svc) begin
            lru[idx_q] <= hit0;
        end
    end

    icache_way #(
        .SETS(SETS)
    ) u_way0 (
        .clk    (clk),
        .reset  (reset),
        .we     (we0),
        .waddr  (idx_q),
        .wtag   (tag_q),
        .wline  (line_data),
        .raddr  (ram_idx),
        .cmp_tag(tag_q),
        .hit    (hit0),
        .rline  (rline0)
    );

    icache_way #(
        .SETS(SETS)
    ) u_way1 (
        .clk    (clk),
        .reset  (reset),
        .we     (we1),
        .waddr  (idx_q),
        .wtag   (tag_q),
        .wline  (line_data),
        .raddr  (ram_idx),
        .cmp_tag(tag_q),
        .hit    (hit1),
        .rline  (rline1)
    );

    assign hit_word  = hit1 ? rline1[sel_q*WORD_W +: WORD_W] : rline0[sel_q*WORD_W +: WORD_W];
    assign fill_word = line_data[sel_q*WORD_W +: WORD_W];

    // forward straight from the refill line
    assign inst       = (state == CS_MISS) ? fill_word : hit_word;
    assign inst_valid = fill || hit_svc;

    assign line_req  = miss;
    assign line_addr = {addr_q[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    // a line only comes back for the outstanding miss
    assert property (@(posedge clk) disable iff (reset) line_valid |-> state == CS_MISS);

    // a tag lives in at most one way of a set
    assert property (@(posedge clk) disable iff (reset) req_q |-> !(hit0 && hit1));

    assert property (@(posedge clk) reset ##1 reset |-> !inst_valid);

endmodule

`default_nettype wire

/* verilog/icache_way.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_way #(
    parameter int  SETS  = 128,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = 32 - IDX_W - icache_pkg::OFFSET_BITS
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              we,
    input  logic [IDX_W-1:0]  waddr,
    input  logic [TAG_W-1:0]  wtag,
    input  icache_pkg::line_t wline,
    input  logic [IDX_W-1:0]  raddr,
    input  logic [TAG_W-1:0]  cmp_tag,
    output logic              hit,
    output icache_pkg::line_t rline
);

    import icache_pkg::*;

    localparam int WORD_W = $bits(word_t);

    logic [IDX_W-1:0] init_idx;
    logic             init_busy;
    logic             tv_we;
    logic [IDX_W-1:0] tv_waddr;
    logic [TAG_W:0]   tv_wdata;
    logic [TAG_W:0]   tv_rdata;

    // valid clear sweep, one set per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            init_idx  <= '0;
            init_busy <= 1'b1;
        end else if (init_busy) begin
            init_idx <= init_idx + 1'b1;
            if (init_idx == IDX_W'(SETS - 1)) begin
                init_busy <= 1'b0;
            end
        end
    end

    for (genvar b = 0; b < WORDS_PER_LINE; b++) begin : g_bank
        sdp_ram #(
            .WIDTH(WORD_W),
            .DEPTH(SETS)
        ) u_bank (
            .clk  (clk),
            .we   (we),
            .waddr(waddr),
            .wdata(wline[b*WORD_W +: WORD_W]),
            .raddr(raddr),
            .rdata(rline[b*WORD_W +: WORD_W])
        );
    end

    // tag ram shared between the sweep and line fills
    assign tv_we    = we | init_busy;
    assign tv_waddr = init_busy ? init_idx : waddr;
    assign tv_wdata = init_busy ? '0 : {1'b1, wtag};

    sdp_ram #(
        .WIDTH(TAG_W + 1),
        .DEPTH(SETS)
    ) u_tagv (
        .clk  (clk),
        .we   (tv_we),
        .waddr(tv_waddr),
        .wdata(tv_wdata),
        .raddr(raddr),
        .rdata(tv_rdata)
    );

    // valid bit on top
    assign hit = tv_rdata[TAG_W] && (tv_rdata[TAG_W-1:0] == cmp_tag);

endmodule

`default_nettype wire

/* verilog/sdp_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module sdp_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 128
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [WIDTH-1:0]         wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0]         rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    // read-first on a same-address collision
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

/* verilog/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  word_t;
    // word k sits in bits 32k+31:32k
    typedef logic [255:0] line_t;

    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_BITS    = 5;

    // word select within a line, address bits 4:2
    localparam int WORD_SEL_LSB  = 2;
    localparam int WORD_SEL_BITS = 3;

    // cache control
    typedef enum logic [1:0] {
        CS_RUN,
        CS_MISS,
        CS_FILL
    } cache_state_t;

    // refill engine
    typedef enum logic [1:0] {
        RF_IDLE,
        RF_ADDR,
        RF_DATA,
        RF_DONE
    } refill_state_t;

endpackage

`default_nettype wire
